//--- include/mem_board_settings.svh
// --------------------
// Board geometry macros
// Banks, lanes, chip and host widths
// --------------------

`ifndef MEM_BOARD_SETTINGS_SVH
`define MEM_BOARD_SETTINGS_SVH

// Board arrangement
`define MB_BANKS      4                          // Banks of chips
`define MB_LANES      4                          // Chips per bank, one per nibble lane
`define MB_BANK_W     2                          // Bank select field

// Single chip
`define MB_CHIP_AW    12                         // 4K locations per chip
`define MB_CHIP_DEPTH (1 << `MB_CHIP_AW)         // Words per chip
`define MB_NIB_W      4                          // Chip data width

// Host side
`define MB_ADDR_W     (`MB_BANK_W + `MB_CHIP_AW) // 14-bit host address
`define MB_DATA_W     (`MB_LANES * `MB_NIB_W)    // 16-bit host word

`endif

//--- hdl/mem_board_pkg.sv
// --------------------
// Shared types for the memory board
// Host cycle kinds and clear FSM states
// --------------------

package mem_board_pkg;

   // Host cycle as seen through cs_n and we_n
   typedef enum logic [1:0] {
      CYC_IDLE  = 2'd0,    // cs_n high
      CYC_READ  = 2'd1,    // cs_n low, we_n high
      CYC_WRITE = 2'd2     // cs_n low, we_n low
   } bus_cycle_e;

   // Clear sequencer states
   // CLR_RESET is held while reset_n is low
   // and already writes address 0 on the edge that leaves it
   typedef enum logic [1:0] {
      CLR_RESET = 2'd0,    // In reset, sweep armed at address 0
      CLR_SWEEP = 2'd1,    // Zero fill of addresses 1 to 4095
      CLR_DONE  = 2'd2     // Host owns the bus
   } clear_state_e;

endpackage

//--- hdl/sram_4kx4.sv
// --------------------
// 4Kx4 static RAM chip on block RAM
// Active-low select and write enable
// --------------------

`timescale 1ns/1ps
`include "mem_board_settings.svh"

module sram_4kx4 (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic [`MB_CHIP_AW-1:0] addr,     // Chip address
   input  logic                   ce_n,     // Chip select
   input  logic                   we_n,     // Write enable
   input  logic [`MB_NIB_W-1:0]   din,      // Write nibble
   output logic [`MB_NIB_W-1:0]   dout      // Read nibble, zero when not driving
);

   logic [`MB_NIB_W-1:0] mem [`MB_CHIP_DEPTH];  // Storage array
   logic [`MB_NIB_W-1:0] dout_q;                // Output register

   // Single port, write first priority over the read load
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         mem[addr] <= '0;                       // Only the addressed cell
      end else if (!ce_n) begin
         if (!we_n) begin
            mem[addr] <= din;                   // Write cycle
         end else begin
            dout_q <= mem[addr];                // Read cycle loads register
         end
      end
   end

   // The real part tristates here
   // On the board an undriven lane reads as zero
   assign dout = (!ce_n && we_n) ? dout_q : '0;

endmodule

//--- hdl/board_decoder.sv
// --------------------
// Clear sequencer and host cycle decode
// Per-bank chip selects for the chip array
// --------------------

`timescale 1ns/1ps
`include "mem_board_settings.svh"

module board_decoder (
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic [`MB_ADDR_W-1:0]     addr,       // Host address
   input  logic                      cs_n,       // Host select
   input  logic                      we_n,       // Host write enable
   input  logic [`MB_DATA_W-1:0]     wdata,      // Host write word
   output logic [`MB_CHIP_AW-1:0]    chip_addr,  // Shared by all chips
   output logic [`MB_DATA_W-1:0]     chip_din,   // Sliced by lane at the chips
   output logic                      chip_we_n,  // Shared by all chips
   output logic [`MB_BANKS-1:0]      bank_ce_n,  // One select per bank
   output mem_board_pkg::bus_cycle_e cycle,      // To collector
   output logic [`MB_BANK_W-1:0]     bank_sel,   // To collector
   output logic                      addr_chg,   // Chip address moved since last edge
   output logic                      clearing    // Sweep in progress
);
   import mem_board_pkg::*;

   clear_state_e              clr_state;  // Clear FSM
   logic [`MB_CHIP_AW-1:0]    sweep_cnt;  // Sweep address
   logic [`MB_CHIP_AW-1:0]    addr_q;     // Chip address of the last edge
   logic                      sweep;      // Bus owned by the sequencer
   bus_cycle_e                host_cycle; // Decoded host strobes

   // Clear sequencer
   // Every edge outside CLR_DONE writes zero at sweep_cnt,
   // so 4096 edges after reset release cover the whole chip
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         clr_state <= CLR_RESET;
         sweep_cnt <= '0;
      end else begin
         case (clr_state)
            CLR_RESET: begin
               clr_state <= CLR_SWEEP;            // Address 0 written now
               sweep_cnt <= sweep_cnt + 1'b1;
            end
            CLR_SWEEP: begin
               if (&sweep_cnt) begin
                  clr_state <= CLR_DONE;          // Last address written now
               end
               sweep_cnt <= sweep_cnt + 1'b1;     // Wraps back to 0
            end
            default: begin
               clr_state <= CLR_DONE;             // Stays here until reset
            end
         endcase
      end
   end

   assign sweep    = (clr_state != CLR_DONE);
   assign clearing = sweep;

   // Host strobes
   always_comb begin
      if (cs_n) begin
         host_cycle = CYC_IDLE;
      end else if (we_n) begin
         host_cycle = CYC_READ;
      end else begin
         host_cycle = CYC_WRITE;
      end
   end

   assign bank_sel = addr[`MB_ADDR_W-1 -: `MB_BANK_W];  // Upper bits pick the bank

   // Chip side drive
   always_comb begin
      if (sweep) begin
         chip_addr = sweep_cnt;
         chip_din  = '0;                          // Zero fill
         chip_we_n = 1'b0;
         bank_ce_n = '0;                          // Every chip at once
         cycle     = CYC_IDLE;                    // Host ignored
      end else begin
         chip_addr = addr[`MB_CHIP_AW-1:0];
         chip_din  = wdata;
         chip_we_n = we_n;
         bank_ce_n = '1;
         if (host_cycle != CYC_IDLE) begin
            bank_ce_n[bank_sel] = 1'b0;           // Addressed bank only
         end
         cycle     = host_cycle;
      end
   end

   // Low address history for the read valid logic
   // Bank bits are tracked in the collector
   always_ff @(posedge clk) begin
      addr_q <= addr[`MB_CHIP_AW-1:0];
   end

   assign addr_chg = (addr[`MB_CHIP_AW-1:0] != addr_q);

endmodule

//--- hdl/read_collector.sv
// --------------------
// Read data collector
// Lane join, bank select, read valid
// --------------------

`timescale 1ns/1ps
`include "mem_board_settings.svh"

module read_collector (
   input  logic                              clk,
   input  logic                              reset_n,
   input  mem_board_pkg::bus_cycle_e         cycle,      // Current host cycle
   input  logic [`MB_BANK_W-1:0]             bank_sel,   // Current bank
   input  logic                              addr_chg,   // Chip address moved
   input  logic [`MB_BANKS*`MB_DATA_W-1:0]   chip_dout,  // Bank by lane nibbles
   output logic [`MB_DATA_W-1:0]             rdata,      // Read word, zero when not valid
   output logic                              rdata_valid
);
   import mem_board_pkg::*;

   logic [`MB_DATA_W-1:0] bank_word [`MB_BANKS];  // Joined lanes per bank
   logic [`MB_DATA_W-1:0] sel_word;               // Word of the addressed bank
   logic                  rd_q;                   // Last edge was a read
   logic [`MB_BANK_W-1:0] bank_q;                 // Bank of the last edge
   logic                  same_read;              // Last edge read this location

   // Each chip owns one nibble of its bank word
   always_comb begin
      for (int b = 0; b < `MB_BANKS; b++) begin
         for (int l = 0; l < `MB_LANES; l++) begin
            bank_word[b][l*`MB_NIB_W +: `MB_NIB_W] =
               chip_dout[(b*`MB_LANES + l)*`MB_NIB_W +: `MB_NIB_W];
         end
      end
   end

   assign sel_word = bank_word[bank_sel];  // Unselected banks read zero anyway

   // History of the previous edge
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         rd_q   <= 1'b0;
         bank_q <= '0;
      end else begin
         rd_q   <= (cycle == CYC_READ);   // Chips loaded their registers
         bank_q <= bank_sel;
      end
   end

   // Chip registers hold this location only if the last edge read it
   assign same_read = rd_q && (bank_q == bank_sel) && !addr_chg;

   assign rdata_valid = same_read && (cycle == CYC_READ);  // Read still held
   assign rdata       = rdata_valid ? sel_word : '0;

endmodule

//--- hdl/mem_board_top.sv
// --------------------
// 16K x 16 memory board top
// Decoder, 4 x 4 chip array, read collector
// --------------------

`timescale 1ns/1ps
`include "mem_board_settings.svh"

module mem_board_top (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic [`MB_ADDR_W-1:0] addr,         // Host address
   input  logic                  cs_n,         // Host select
   input  logic                  we_n,         // Host write enable
   input  logic [`MB_DATA_W-1:0] wdata,        // Host write word
   output logic [`MB_DATA_W-1:0] rdata,        // Host read word
   output logic                  rdata_valid,  // Read word is good
   output logic                  clearing      // Zero fill running
);
   import mem_board_pkg::*;

   logic [`MB_CHIP_AW-1:0]            chip_addr;
   logic [`MB_DATA_W-1:0]             chip_din;
   logic                              chip_we_n;
   logic [`MB_BANKS-1:0]              bank_ce_n;
   bus_cycle_e                        cycle;
   logic [`MB_BANK_W-1:0]             bank_sel;
   logic                              addr_chg;
   logic [`MB_BANKS*`MB_DATA_W-1:0]   chip_dout;   // Bank major, lane minor

   board_decoder u_decoder (
      .clk       (clk),
      .reset_n   (reset_n),
      .addr      (addr),
      .cs_n      (cs_n),
      .we_n      (we_n),
      .wdata     (wdata),
      .chip_addr (chip_addr),
      .chip_din  (chip_din),
      .chip_we_n (chip_we_n),
      .bank_ce_n (bank_ce_n),
      .cycle     (cycle),
      .bank_sel  (bank_sel),
      .addr_chg  (addr_chg),
      .clearing  (clearing)
   );

   // Chip array
   // Lane l of every bank shares data bits of the host word
   for (genvar b = 0; b < `MB_BANKS; b++) begin : g_bank
      for (genvar l = 0; l < `MB_LANES; l++) begin : g_lane
         sram_4kx4 u_chip (
            .clk     (clk),
            .reset_n (reset_n),
            .addr    (chip_addr),
            .ce_n    (bank_ce_n[b]),                 // Bank wide select
            .we_n    (chip_we_n),
            .din     (chip_din[l*`MB_NIB_W +: `MB_NIB_W]),
            .dout    (chip_dout[(b*`MB_LANES + l)*`MB_NIB_W +: `MB_NIB_W])
         );
      end
   end

   read_collector u_collector (
      .clk         (clk),
      .reset_n     (reset_n),
      .cycle       (cycle),
      .bank_sel    (bank_sel),
      .addr_chg    (addr_chg),
      .chip_dout   (chip_dout),
      .rdata       (rdata),
      .rdata_valid (rdata_valid)
   );

endmodule

//--- sim/tb_mem_board.sv
// --------------------
// Memory board testbench
// Stimulus table with LFSR data and reference memory
// Compare tasks, run limit, result report
// --------------------

`timescale 1ns/1ps
`include "mem_board_settings.svh"

module tb_mem_board;
   import mem_board_pkg::*;

   localparam int ROW_MAX = 64;                    // Table capacity
   localparam int POOL_N  = 6;                     // Random address pool size

   logic                  clk;
   logic                  reset_n;
   logic [`MB_ADDR_W-1:0] addr;
   logic                  cs_n;
   logic                  we_n;
   logic [`MB_DATA_W-1:0] wdata;
   logic [`MB_DATA_W-1:0] rdata;
   logic                  rdata_valid;
   logic                  clearing;

   // Stimulus table with one row per host operation
   bus_cycle_e            row_op   [ROW_MAX];
   logic [`MB_ADDR_W-1:0] row_addr [ROW_MAX];
   logic [`MB_DATA_W-1:0] row_data [ROW_MAX];
   int                    row_hold [ROW_MAX];     // Cycles the strobes are held
   int                    row_count;
   int                    hold_sum;

   logic [`MB_DATA_W-1:0] model_mem [1 << `MB_ADDR_W];  // Reference memory
   logic [`MB_ADDR_W-1:0] pool_addr [POOL_N];            // Reused random locations
   logic [31:0]           lfsr_state;
   logic                  prev_read;              // Last cycle was a read
   logic [`MB_ADDR_W-1:0] prev_addr;              // Address of the last cycle
   clear_state_e          phase;                  // Board phase for messages
   logic                  sweeping;
   int                    clear_cycles;
   int                    cycle_count;
   int                    cycle_limit;

   mem_board_top dut (
      .clk         (clk),
      .reset_n     (reset_n),
      .addr        (addr),
      .cs_n        (cs_n),
      .we_n        (we_n),
      .wdata       (wdata),
      .rdata       (rdata),
      .rdata_valid (rdata_valid),
      .clearing    (clearing)
   );

   always #5 clk = ~clk;                           // 10 ns period

   // Run limit
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         abort_run($sformatf("Run timed out after %0d cycles in phase %s",
                             cycle_count, phase.name()));
      end
   end

   task automatic abort_run(input string reason);
      if (reason != "") begin
         $display("%s", reason);
      end
      $display("=== FAIL ===");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic check_word(input string name, input logic [`MB_DATA_W-1:0] exp,
                             input logic [`MB_DATA_W-1:0] act);
      if (act !== exp) begin
         $display("ERR %0t ns %s expected %h actual %h (%s)",
                  $time, name, exp, act, phase.name());
         abort_run("");
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %0t ns %s expected %b actual %b (%s)",
                  $time, name, exp, act, phase.name());
         abort_run("");
      end
   endtask

   // Galois LFSR stepped once per bit taken
   function automatic logic lfsr_step();
      logic lsb;
      lsb        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
         lfsr_state = lfsr_state ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
      end
      return lsb;
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_step()};
      end
      return v;
   endfunction

   function automatic logic [`MB_DATA_W-1:0] rand_word();
      logic [31:0] v;
      v = take_bits(`MB_DATA_W);
      return v[`MB_DATA_W-1:0];
   endfunction

   task automatic add_row(input bus_cycle_e op, input logic [`MB_ADDR_W-1:0] a,
                          input logic [`MB_DATA_W-1:0] d, input int hold);
      row_op[row_count]   = op;
      row_addr[row_count] = a;
      row_data[row_count] = d;
      row_hold[row_count] = hold;
      hold_sum            = hold_sum + hold;
      row_count++;
   endtask

   task automatic build_table();
      logic [`MB_ADDR_W-1:0] a;
      logic [31:0]           v;
      row_count = 0;
      hold_sum  = 0;
      for (int i = 0; i < POOL_N; i++) begin
         v            = take_bits(`MB_ADDR_W);
         pool_addr[i] = v[`MB_ADDR_W-1:0];
      end
      // Never written locations in every bank
      // 0x2005 took a host write during the sweep
      add_row(CYC_READ,  14'h0000, '0, 2);
      add_row(CYC_READ,  14'h1abc, '0, 2);
      add_row(CYC_READ,  14'h2005, '0, 2);
      add_row(CYC_READ,  14'h3fff, '0, 3);
      add_row(CYC_IDLE,  14'h0000, 16'hffff, 2);
      // Same low address in every bank
      for (int b = 0; b < `MB_BANKS; b++) begin
         a = {b[`MB_BANK_W-1:0], 12'h123};
         add_row(CYC_WRITE, a, rand_word(), 1);
      end
      add_row(CYC_IDLE,  14'h0123, '0, 1);
      for (int b = 0; b < `MB_BANKS; b++) begin
         a = {b[`MB_BANK_W-1:0], 12'h123};
         add_row(CYC_READ, a, '0, 2);
      end
      // One lane at a time
      add_row(CYC_WRITE, 14'h0300, 16'h000f, 1);
      add_row(CYC_WRITE, 14'h0301, 16'h00f0, 1);
      add_row(CYC_WRITE, 14'h2302, 16'h0f00, 2);   // Held write
      add_row(CYC_WRITE, 14'h3303, 16'hf000, 1);
      add_row(CYC_WRITE, 14'h1301, 16'h9c36, 1);
      add_row(CYC_IDLE,  14'h0000, 16'hffff, 1);
      // Held reads with the address moving inside the read
      add_row(CYC_READ,  14'h0300, '0, 3);
      add_row(CYC_READ,  14'h0301, '0, 3);         // Low bits move
      add_row(CYC_READ,  14'h1301, '0, 3);         // Bank bits move
      add_row(CYC_READ,  14'h2302, '0, 2);
      add_row(CYC_READ,  14'h3303, '0, 2);
      add_row(CYC_IDLE,  14'h3303, '0, 1);
      add_row(CYC_READ,  14'h3303, '0, 2);         // Fresh read after idle
      // Random data over a small pool with overwrites
      add_row(CYC_WRITE, pool_addr[0], rand_word(), 1);
      add_row(CYC_WRITE, pool_addr[1], rand_word(), 1);
      add_row(CYC_WRITE, pool_addr[2], rand_word(), 1);
      add_row(CYC_READ,  pool_addr[0], '0, 2);
      add_row(CYC_WRITE, pool_addr[0], rand_word(), 1);
      add_row(CYC_READ,  pool_addr[0], '0, 2);
      add_row(CYC_READ,  pool_addr[1], '0, 2);
      add_row(CYC_WRITE, pool_addr[3], rand_word(), 2);
      add_row(CYC_WRITE, pool_addr[1], rand_word(), 1);
      add_row(CYC_READ,  pool_addr[1], '0, 2);
      add_row(CYC_READ,  pool_addr[3], '0, 2);
      add_row(CYC_READ,  pool_addr[2], '0, 2);
      add_row(CYC_WRITE, pool_addr[4], rand_word(), 1);
      add_row(CYC_WRITE, pool_addr[5], rand_word(), 1);
      add_row(CYC_READ,  pool_addr[5], '0, 2);
      add_row(CYC_READ,  pool_addr[4], '0, 2);
      add_row(CYC_WRITE, pool_addr[4], rand_word(), 1);
      add_row(CYC_READ,  pool_addr[4], '0, 3);
      add_row(CYC_IDLE,  14'h0000, '0, 2);
   endtask

   task automatic drive_bus(input bus_cycle_e op, input logic [`MB_ADDR_W-1:0] a,
                            input logic [`MB_DATA_W-1:0] d);
      addr  <= a;
      wdata <= d;
      cs_n  <= (op == CYC_IDLE);
      we_n  <= (op != CYC_WRITE);
   endtask

   // Valid only from the second edge of a read held at one address
   task automatic apply_row(input int r);
      logic                  exp_valid;
      logic [`MB_DATA_W-1:0] exp_word;
      for (int h = 0; h < row_hold[r]; h++) begin
         @(posedge clk);
         drive_bus(row_op[r], row_addr[r], row_data[r]);
         if (h == 0 && row_op[r] == CYC_WRITE) begin
            model_mem[row_addr[r]] = row_data[r];  // Lands on the next edge
         end
         @(negedge clk);
         exp_valid = (row_op[r] == CYC_READ) && prev_read && (prev_addr == row_addr[r]);
         exp_word  = exp_valid ? model_mem[row_addr[r]] : '0;
         check_flag("clearing", 1'b0, clearing);
         check_flag("rdata_valid", exp_valid, rdata_valid);
         check_word("rdata", exp_word, rdata);
         prev_read = (row_op[r] == CYC_READ);
         prev_addr = row_addr[r];
      end
   endtask

   initial begin
      clk          = 1'b0;
      reset_n      = 1'b0;
      addr         = '0;
      cs_n         = 1'b1;
      we_n         = 1'b1;
      wdata        = '0;
      cycle_count  = 0;
      cycle_limit  = 0;
      clear_cycles = 0;
      prev_read    = 1'b0;
      prev_addr    = '0;
      lfsr_state   = 32'h65d9993d;
      phase        = CLR_RESET;
      for (int i = 0; i < (1 << `MB_ADDR_W); i++) begin
         model_mem[i] = '0;
      end
      build_table();
      cycle_limit = 8 + `MB_CHIP_DEPTH + hold_sum + 200;

      // Host holds a read through reset
      for (int i = 0; i < 8; i++) begin
         @(negedge clk);
         check_flag("clearing", 1'b1, clearing);
         check_flag("rdata_valid", 1'b0, rdata_valid);
         check_word("rdata", '0, rdata);
         @(posedge clk);
         if (i == 0) begin
            drive_bus(CYC_READ, 14'h1abc, '0);
         end
      end
      reset_n <= 1'b1;
      drive_bus(CYC_IDLE, 14'h0000, '0);
      phase    = CLR_SWEEP;

      // Count sweep cycles while the host tries a write and a read
      sweeping = 1'b1;
      while (sweeping) begin
         @(negedge clk);
         if (clearing) begin
            clear_cycles++;
            check_flag("rdata_valid", 1'b0, rdata_valid);
            check_word("rdata", '0, rdata);
            @(posedge clk);
            case (clear_cycles)
               4000: drive_bus(CYC_WRITE, 14'h2005, 16'hbeef);
               4002: drive_bus(CYC_READ, 14'h2005, '0);
               4010: drive_bus(CYC_IDLE, 14'h0000, '0);
               default: ;
            endcase
         end else begin
            sweeping = 1'b0;
         end
      end
      if (clear_cycles != `MB_CHIP_DEPTH) begin
         abort_run($sformatf("Clear sweep lasted %0d cycles instead of %0d",
                             clear_cycles, `MB_CHIP_DEPTH));
      end
      phase = CLR_DONE;
      $display("Clear sweep took %0d cycles, %0d table rows follow", clear_cycles, row_count);
      check_flag("rdata_valid", 1'b0, rdata_valid);

      for (int r = 0; r < row_count; r++) begin
         apply_row(r);
      end

      $display("=== PASS ===");
      $finish;
   end

endmodule

//--- src.f
+incdir+include
hdl/mem_board_pkg.sv
hdl/sram_4kx4.sv
hdl/board_decoder.sv
hdl/read_collector.sv
hdl/mem_board_top.sv
sim/tb_mem_board.sv

//--- Bender.yml
package:
  name: mem_board

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/mem_board_pkg.sv
      - hdl/sram_4kx4.sv
      - hdl/board_decoder.sv
      - hdl/read_collector.sv
      - hdl/mem_board_top.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_mem_board.sv
